/* mem_subsys_top.f */
source/rv_mem_pkg.sv
source/data_ram.sv
source/mem_unit.sv
source/mem_stage.sv
source/mem_subsys_top.sv
verif/mem_subsys_assert.sv
verif/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - source/rv_mem_pkg.sv
  - source/data_ram.sv
  - source/mem_unit.sv
  - source/mem_stage.sv
  - source/mem_subsys_top.sv
  - target: test
    files:
      - verif/mem_subsys_assert.sv
      - verif/tb_mem_subsys.sv

/* verif/tb_mem_subsys.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem testbench driving loads, stores and empty items under
// random back-pressure and checking them against a shadow memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_mem_subsys
  import rv_mem_pkg::*;
;

  localparam int ADDR_W         = 8;
  localparam int NUM_WORDS      = 16;
  localparam int ROUNDS         = 4;
  localparam int NUM_NOPS       = 8;
  localparam int NUM_STALLS     = 4;
  localparam int STALL_CYCLES   = 24;
  localparam int TOTAL_ITEMS    = NUM_WORDS + 4 * ROUNDS * 8 + 2 * NUM_NOPS + 2 * NUM_STALLS;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_ITEMS + 200;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] inst;
    ridx_t           rd;
    logic            rd_wen;
    logic [XLEN-1:0] rd_wdata;
    logic            nocmt;
    logic            skipcmt;
    logic [XLEN-1:0] rdata;
  } item_t;

  logic            clk = 1'b0;
  logic            rst;
  logic            i_executed_req;
  logic            o_executed_ack;
  logic            o_memoryed_req;
  logic            i_memoryed_ack;
  logic [XLEN-1:0] i_pc;
  logic [ILEN-1:0] i_inst;
  logic [XLEN-1:0] i_addr;
  logic            i_ren;
  funct3_t         i_funct3;
  logic            i_wen;
  logic [XLEN-1:0] i_wdata;
  ridx_t           i_rd;
  logic            i_rd_wen;
  logic [XLEN-1:0] i_rd_wdata;
  logic            i_nocmt;
  logic            i_skipcmt;
  logic [XLEN-1:0] o_pc;
  logic [ILEN-1:0] o_inst;
  ridx_t           o_rd;
  logic            o_rd_wen;
  logic [XLEN-1:0] o_rd_wdata;
  logic            o_nocmt;
  logic            o_skipcmt;
  logic [XLEN-1:0] o_rdata;

  integer          seed = 24345;
  // ack stream keeps its own seed so it never reorders the stimulus values.
  integer          ack_seed = 24345 + 1;
  int              errors = 0;
  int              issued = 0;
  int              cycles = 0;
  logic            force_stall = 1'b0;
  logic [XLEN-1:0] shadow [256];
  item_t           exp_q [$];
  string           name_q [$];

  mem_subsys_top #(
    .ADDR_W (ADDR_W)
  ) uut (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .o_executed_ack (o_executed_ack),
    .o_memoryed_req (o_memoryed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_addr         (i_addr),
    .i_ren          (i_ren),
    .i_funct3       (i_funct3),
    .i_wen          (i_wen),
    .i_wdata        (i_wdata),
    .i_rd           (i_rd),
    .i_rd_wen       (i_rd_wen),
    .i_rd_wdata     (i_rd_wdata),
    .i_nocmt        (i_nocmt),
    .i_skipcmt      (i_skipcmt),
    .o_pc           (o_pc),
    .o_inst         (o_inst),
    .o_rd           (o_rd),
    .o_rd_wen       (o_rd_wen),
    .o_rd_wdata     (o_rd_wdata),
    .o_nocmt        (o_nocmt),
    .o_skipcmt      (o_skipcmt),
    .o_rdata        (o_rdata)
  );

  always #20 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {rand32(), rand32()};
  endfunction

  // random word among the ones cleared at the start.
  function automatic logic [XLEN-1:0] word_base();
    logic [XLEN-1:0] a;
    logic [31:0]     r;
    r = rand32();
    a = '0;
    a[6:3] = r[3:0];
    return a;
  endfunction

  // random byte offset aligned to 2**size_log2 bytes.
  function automatic logic [2:0] aligned_lane(input int size_log2);
    logic [31:0] r;
    r = rand32();
    return r[2:0] & (3'b111 << size_log2);
  endfunction

  function automatic logic [XLEN-1:0] ref_load(input funct3_t f3, input logic [XLEN-1:0] addr,
                                               input logic [XLEN-1:0] word);
    logic [XLEN-1:0] sh;
    sh = word >> (8 * addr[2:0]);
    case (f3)
      F3_LB:   return {{(XLEN-8){sh[7]}}, sh[7:0]};
      F3_LH:   return {{(XLEN-16){sh[15]}}, sh[15:0]};
      F3_LW:   return {{(XLEN-32){sh[31]}}, sh[31:0]};
      F3_LD:   return sh;
      F3_LBU:  return {{(XLEN-8){1'b0}}, sh[7:0]};
      F3_LHU:  return {{(XLEN-16){1'b0}}, sh[15:0]};
      F3_LWU:  return {{(XLEN-32){1'b0}}, sh[31:0]};
      default: return '0;
    endcase
  endfunction

  task automatic store_shadow(input funct3_t f3, input logic [XLEN-1:0] addr,
                              input logic [XLEN-1:0] wdata);
    int nbytes;
    int idx;
    nbytes = 1 << f3[1:0];
    idx = addr[ADDR_W+2:3];
    for (int b = 0; b < nbytes; b++) begin
      shadow[idx][8*(addr[2:0]+b) +: 8] = wdata[8*b +: 8];
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic send_item(input string name, input logic [XLEN-1:0] addr, input logic ren,
                           input logic wen, input funct3_t f3, input logic [XLEN-1:0] wdata);
    item_t       it;
    logic [31:0] r;
    it.pc       = rand64();
    it.inst     = rand32();
    it.rd_wdata = rand64();
    r           = rand32();
    it.rd       = r[RIDX_W-1:0];
    it.rd_wen   = r[8];
    it.nocmt    = r[9];
    it.skipcmt  = r[10];
    it.rdata    = ren ? ref_load(f3, addr, shadow[addr[ADDR_W+2:3]]) : '0;
    if (wen) begin
      store_shadow(f3, addr, wdata);
    end
    @(negedge clk);
    i_executed_req = 1'b1;
    i_pc           = it.pc;
    i_inst         = it.inst;
    i_addr         = addr;
    i_ren          = ren;
    i_funct3       = f3;
    i_wen          = wen;
    i_wdata        = wdata;
    i_rd           = it.rd;
    i_rd_wen       = it.rd_wen;
    i_rd_wdata     = it.rd_wdata;
    i_nocmt        = it.nocmt;
    i_skipcmt      = it.skipcmt;
    @(posedge clk);
    while (!o_executed_ack) begin
      @(posedge clk);
    end
    exp_q.push_back(it);
    name_q.push_back(name);
    issued++;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      i_executed_req = 1'b0;
    end
  endtask

  task automatic drain();
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input logic [XLEN-1:0] exp_val, input logic [XLEN-1:0] act_val);
    errors++;
    $display("Mismatch %s %s expected %h actual %h", test, field, exp_val, act_val);
  endtask

  // writeback side is stalled at random, or held off completely on request.
  always @(negedge clk) begin : ack_drive
    logic [31:0] r;
    r = $random(ack_seed);
    i_memoryed_ack = !force_stall && (r[1:0] != 2'b00);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checker.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin : compare
    item_t exp_it;
    string test;
    if (!rst && o_memoryed_req && i_memoryed_ack) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("an item nobody sent reached writeback, pc %h", o_pc);
      end else begin
        exp_it = exp_q.pop_front();
        test   = name_q.pop_front();
        if (o_pc !== exp_it.pc) report_mismatch(test, "pc", exp_it.pc, o_pc);
        if (o_inst !== exp_it.inst) report_mismatch(test, "inst", exp_it.inst, o_inst);
        if (o_rd !== exp_it.rd) report_mismatch(test, "rd", exp_it.rd, o_rd);
        if (o_rd_wen !== exp_it.rd_wen) report_mismatch(test, "rd_wen", exp_it.rd_wen, o_rd_wen);
        if (o_rd_wdata !== exp_it.rd_wdata) begin
          report_mismatch(test, "rd_wdata", exp_it.rd_wdata, o_rd_wdata);
        end
        if (o_nocmt !== exp_it.nocmt) report_mismatch(test, "nocmt", exp_it.nocmt, o_nocmt);
        if (o_skipcmt !== exp_it.skipcmt) begin
          report_mismatch(test, "skipcmt", exp_it.skipcmt, o_skipcmt);
        end
        if (o_rdata !== exp_it.rdata) report_mismatch(test, "rdata", exp_it.rdata, o_rdata);
      end
    end else if (!rst && !o_memoryed_req) begin
      if (o_pc !== '0 || o_inst !== '0 || o_rd !== '0 || o_rd_wen !== 1'b0 ||
          o_rd_wdata !== '0 || o_nocmt !== 1'b0 || o_skipcmt !== 1'b0) begin
        errors++;
        $display("pass-through outputs are not zero while the stage is empty");
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d items never reached writeback",
               cycles, exp_q.size());
      $display("errors: %0d", errors);
      $display("sim failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [XLEN-1:0] addr;
    logic [31:0]     r;
    rst            = 1'b1;
    i_executed_req = 1'b0;
    i_memoryed_ack = 1'b0;
    i_pc           = '0;
    i_inst         = '0;
    i_addr         = '0;
    i_ren          = 1'b0;
    i_funct3       = '0;
    i_wen          = 1'b0;
    i_wdata        = '0;
    i_rd           = '0;
    i_rd_wen       = 1'b0;
    i_rd_wdata     = '0;
    i_nocmt        = 1'b0;
    i_skipcmt      = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    if (o_memoryed_req !== 1'b0 || o_executed_ack !== 1'b1) begin
      errors++;
      $display("handshake outputs are wrong right after reset");
    end
    // clear every word the tests touch.
    for (int w = 0; w < NUM_WORDS; w++) begin
      send_item("init", 64'(w * 8), 1'b0, 1'b1, F3_SD, '0);
    end
    for (int s = 0; s < 4; s++) begin
      for (int n = 0; n < ROUNDS; n++) begin
        addr = word_base();
        addr[2:0] = aligned_lane(s);
        send_item("store_load", addr, 1'b0, 1'b1, s[2:0], rand64());
        for (int k = 0; k < 7; k++) begin
          addr[2:0] = aligned_lane(k & 3);
          send_item("store_load", addr, 1'b1, 1'b0, k[2:0], '0);
        end
      end
    end
    // items that neither read nor write must leave the word alone.
    for (int n = 0; n < NUM_NOPS; n++) begin
      addr = word_base();
      r = rand32();
      send_item("nop", addr | 64'(r[2:0]), 1'b0, 1'b0, r[6:4], rand64());
      send_item("nop_check", addr, 1'b1, 1'b0, F3_LD, '0);
    end
    for (int n = 0; n < NUM_STALLS; n++) begin
      drain();
      addr = word_base();
      r = rand32();
      addr[2:0] = aligned_lane(r[1:0]);
      send_item("stall_store", addr, 1'b0, 1'b1, {1'b0, r[1:0]}, rand64());
      force_stall = 1'b1;
      idle_cycles(STALL_CYCLES);
      @(posedge clk);
      force_stall = 1'b0;
      send_item("stall_load", {addr[XLEN-1:3], 3'b000}, 1'b1, 1'b0, F3_LD, '0);
    end
    drain();
    idle_cycles(2);
    if (exp_q.size() != 0 || issued != TOTAL_ITEMS) begin
      errors++;
      $display("%0d items left over, %0d of %0d issued", exp_q.size(), issued, TOTAL_ITEMS);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verif/mem_subsys_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and store-commit properties bound into mem_stage.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_subsys_assert (
  input logic clk,
  input logic rst,
  input logic i_executed_req,
  input logic i_executed_ack,
  input logic i_memoryed_req,
  input logic i_memoryed_ack,
  input logic i_commit
);

  a_req_held : assert property (@(posedge clk) disable iff (rst)
    i_memoryed_req && !i_memoryed_ack |=> i_memoryed_req)
    else $error("o_memoryed_req dropped before it was acked");

  // a second pulse in a row is only allowed for a newly accepted item.
  a_commit_once : assert property (@(posedge clk) disable iff (rst)
    i_commit && !(i_executed_req && i_executed_ack) |=> !i_commit)
    else $error("o_commit lasted longer than one cycle");

  a_commit_valid : assert property (@(posedge clk) disable iff (rst)
    i_commit |-> i_memoryed_req)
    else $error("o_commit high while the stage is empty");

  a_ack_empty : assert property (@(posedge clk) disable iff (rst)
    !i_memoryed_req |-> i_executed_ack)
    else $error("o_executed_ack low while the stage is empty");

endmodule

bind mem_stage mem_subsys_assert u_mem_subsys_assert (
  .clk            (clk),
  .rst            (rst),
  .i_executed_req (i_executed_req),
  .i_executed_ack (o_executed_ack),
  .i_memoryed_req (o_memoryed_req),
  .i_memoryed_ack (i_memoryed_ack),
  .i_commit       (o_commit)
);

/* source/mem_subsys_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory subsystem top level joining the stage register, load/store unit
// and data RAM.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_subsys_top
  import rv_mem_pkg::*;
#(
  parameter int ADDR_W = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_executed_req,
  output logic            o_executed_ack,
  output logic            o_memoryed_req,
  input  logic            i_memoryed_ack,
  input  logic [XLEN-1:0] i_pc,
  input  logic [ILEN-1:0] i_inst,
  input  logic [XLEN-1:0] i_addr,
  input  logic            i_ren,
  input  funct3_t         i_funct3,
  input  logic            i_wen,
  input  logic [XLEN-1:0] i_wdata,
  input  ridx_t           i_rd,
  input  logic            i_rd_wen,
  input  logic [XLEN-1:0] i_rd_wdata,
  input  logic            i_nocmt,
  input  logic            i_skipcmt,
  output logic [XLEN-1:0] o_pc,
  output logic [ILEN-1:0] o_inst,
  output ridx_t           o_rd,
  output logic            o_rd_wen,
  output logic [XLEN-1:0] o_rd_wdata,
  output logic            o_nocmt,
  output logic            o_skipcmt,
  output logic [XLEN-1:0] o_rdata
);

  logic              commit;
  logic [XLEN-1:0]   acc_addr;
  logic              acc_ren;
  logic              acc_wen;
  funct3_t           acc_funct3;
  logic [XLEN-1:0]   acc_wdata;
  logic [ADDR_W-1:0] ram_idx;
  logic [7:0]        ram_be;
  logic              ram_we;
  logic [XLEN-1:0]   ram_wdata;
  logic [XLEN-1:0]   ram_rdata;

  mem_stage u_mem_stage (
    .clk            (clk),
    .rst            (rst),
    .i_executed_req (i_executed_req),
    .o_executed_ack (o_executed_ack),
    .o_memoryed_req (o_memoryed_req),
    .i_memoryed_ack (i_memoryed_ack),
    .i_pc           (i_pc),
    .i_inst         (i_inst),
    .i_addr         (i_addr),
    .i_ren          (i_ren),
    .i_funct3       (i_funct3),
    .i_wen          (i_wen),
    .i_wdata        (i_wdata),
    .i_rd           (i_rd),
    .i_rd_wen       (i_rd_wen),
    .i_rd_wdata     (i_rd_wdata),
    .i_nocmt        (i_nocmt),
    .i_skipcmt      (i_skipcmt),
    .o_commit       (commit),
    .o_acc_addr     (acc_addr),
    .o_acc_ren      (acc_ren),
    .o_acc_wen      (acc_wen),
    .o_acc_funct3   (acc_funct3),
    .o_acc_wdata    (acc_wdata),
    .o_pc           (o_pc),
    .o_inst         (o_inst),
    .o_rd           (o_rd),
    .o_rd_wen       (o_rd_wen),
    .o_rd_wdata     (o_rd_wdata),
    .o_nocmt        (o_nocmt),
    .o_skipcmt      (o_skipcmt)
  );

  mem_unit #(
    .ADDR_W (ADDR_W)
  ) u_mem_unit (
    .i_addr      (acc_addr),
    .i_ren       (acc_ren),
    .i_wen       (acc_wen),
    .i_funct3    (acc_funct3),
    .i_wdata     (acc_wdata),
    .i_commit    (commit),
    .i_ram_rdata (ram_rdata),
    .o_ram_idx   (ram_idx),
    .o_ram_be    (ram_be),
    .o_ram_we    (ram_we),
    .o_ram_wdata (ram_wdata),
    .o_rdata     (o_rdata)
  );

  data_ram #(
    .ADDR_W (ADDR_W)
  ) u_data_ram (
    .clk     (clk),
    .i_idx   (ram_idx),
    .i_we    (ram_we),
    .i_be    (ram_be),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

/* source/mem_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory stage register with req/ack handshakes on both sides.
// holds one item, pulses commit once and gates outputs while empty.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_stage
  import rv_mem_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              i_executed_req,
  output logic              o_executed_ack,
  output logic              o_memoryed_req,
  input  logic              i_memoryed_ack,
  input  logic [XLEN-1:0]   i_pc,
  input  logic [ILEN-1:0]   i_inst,
  input  logic [XLEN-1:0]   i_addr,
  input  logic              i_ren,
  input  funct3_t           i_funct3,
  input  logic              i_wen,
  input  logic [XLEN-1:0]   i_wdata,
  input  ridx_t             i_rd,
  input  logic              i_rd_wen,
  input  logic [XLEN-1:0]   i_rd_wdata,
  input  logic              i_nocmt,
  input  logic              i_skipcmt,
  output logic              o_commit,
  output logic [XLEN-1:0]   o_acc_addr,
  output logic              o_acc_ren,
  output logic              o_acc_wen,
  output funct3_t           o_acc_funct3,
  output logic [XLEN-1:0]   o_acc_wdata,
  output logic [XLEN-1:0]   o_pc,
  output logic [ILEN-1:0]   o_inst,
  output ridx_t             o_rd,
  output logic              o_rd_wen,
  output logic [XLEN-1:0]   o_rd_wdata,
  output logic              o_nocmt,
  output logic              o_skipcmt
);

  logic            valid_q;
  logic            first_q;
  logic            executed_hs;
  logic [XLEN-1:0] pc_q;
  logic [ILEN-1:0] inst_q;
  logic [XLEN-1:0] addr_q;
  logic            ren_q;
  funct3_t         funct3_q;
  logic            wen_q;
  logic [XLEN-1:0] wdata_q;
  ridx_t           rd_q;
  logic            rd_wen_q;
  logic [XLEN-1:0] rd_wdata_q;
  logic            nocmt_q;
  logic            skipcmt_q;

  // accept when empty, or when the held item leaves this cycle.
  assign o_executed_ack = !valid_q || i_memoryed_ack;
  assign executed_hs    = i_executed_req && o_executed_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
    end else begin
      if (executed_hs) begin
        valid_q <= 1'b1;
      end else if (i_memoryed_ack) begin
        valid_q <= 1'b0;
      end
      // only the cycle right after an accept counts as first.
      first_q <= executed_hs;
    end
  end

  always_ff @(posedge clk) begin
    if (executed_hs) begin
      pc_q       <= i_pc;
      inst_q     <= i_inst;
      addr_q     <= i_addr;
      ren_q      <= i_ren;
      funct3_q   <= i_funct3;
      wen_q      <= i_wen;
      wdata_q    <= i_wdata;
      rd_q       <= i_rd;
      rd_wen_q   <= i_rd_wen;
      rd_wdata_q <= i_rd_wdata;
      nocmt_q    <= i_nocmt;
      skipcmt_q  <= i_skipcmt;
    end
  end

  assign o_memoryed_req = valid_q;
  assign o_commit       = first_q;

  // access controls are masked so an empty stage neither reads nor writes.
  assign o_acc_addr   = addr_q;
  assign o_acc_ren    = valid_q && ren_q;
  assign o_acc_wen    = valid_q && wen_q;
  assign o_acc_funct3 = funct3_q;
  assign o_acc_wdata  = wdata_q;

  assign o_pc       = valid_q ? pc_q       : '0;
  assign o_inst     = valid_q ? inst_q     : '0;
  assign o_rd       = valid_q ? rd_q       : '0;
  assign o_rd_wen   = valid_q ? rd_wen_q   : 1'b0;
  assign o_rd_wdata = valid_q ? rd_wdata_q : '0;
  assign o_nocmt    = valid_q ? nocmt_q    : 1'b0;
  assign o_skipcmt  = valid_q ? skipcmt_q  : 1'b0;

endmodule

/* source/mem_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store unit that merges store bytes into their lanes and extracts
// and extends load lanes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mem_unit
  import rv_mem_pkg::*;
#(
  parameter int ADDR_W = 8
) (
  input  logic [XLEN-1:0]   i_addr,
  input  logic              i_ren,
  input  logic              i_wen,
  input  funct3_t           i_funct3,
  input  logic [XLEN-1:0]   i_wdata,
  input  logic              i_commit,
  input  logic [XLEN-1:0]   i_ram_rdata,
  output logic [ADDR_W-1:0] o_ram_idx,
  output logic [7:0]        o_ram_be,
  output logic              o_ram_we,
  output logic [XLEN-1:0]   o_ram_wdata,
  output logic [XLEN-1:0]   o_rdata
);

  logic [2:0]      lane;
  logic [5:0]      bit_sh;
  logic [7:0]      size_mask;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] load_ext;

  assign o_ram_idx = i_addr[ADDR_W+2:3];
  assign lane      = i_addr[2:0];
  assign bit_sh    = {lane, 3'b000};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // store path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (i_funct3)
      F3_SB:   size_mask = 8'h01;
      F3_SH:   size_mask = 8'h03;
      F3_SW:   size_mask = 8'h0f;
      F3_SD:   size_mask = 8'hff;
      default: size_mask = 8'h00;
    endcase
  end

  assign o_ram_be    = size_mask << lane;
  assign o_ram_wdata = i_wdata << bit_sh;
  // write only in the commit cycle, so a stalled store lands once.
  assign o_ram_we    = i_commit && i_wen;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load path.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lane_data = i_ram_rdata >> bit_sh;

  always_comb begin
    case (i_funct3)
      F3_LB: begin
        load_ext = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
      end
      F3_LH: begin
        load_ext = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
      end
      F3_LW: begin
        load_ext = {{(XLEN-32){lane_data[31]}}, lane_data[31:0]};
      end
      F3_LD: begin
        load_ext = lane_data;
      end
      F3_LBU: begin
        load_ext = {{(XLEN-8){1'b0}}, lane_data[7:0]};
      end
      F3_LHU: begin
        load_ext = {{(XLEN-16){1'b0}}, lane_data[15:0]};
      end
      F3_LWU: begin
        load_ext = {{(XLEN-32){1'b0}}, lane_data[31:0]};
      end
      default: begin
        load_ext = '0;
      end
    endcase
  end

  // non-load items return zero.
  assign o_rdata = i_ren ? load_ext : '0;

endmodule

/* source/data_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-bit data RAM, byte write enables, asynchronous read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module data_ram #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] i_idx,
  input  logic              i_we,
  input  logic [7:0]        i_be,
  input  logic [63:0]       i_wdata,
  output logic [63:0]       o_rdata
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [63:0] mem [DEPTH];

  // one write port, each byte lane enabled on its own.
  always_ff @(posedge clk) begin
    if (i_we) begin
      for (int b = 0; b < 8; b++) begin
        if (i_be[b]) begin
          mem[i_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  assign o_rdata = mem[i_idx];

endmodule

/* source/rv_mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv64 memory stage shared widths, access types and funct3 encodings.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rv_mem_pkg;

  // datapath widths.
  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int RIDX_W = 5;

  typedef logic [RIDX_W-1:0] ridx_t;
  typedef logic [2:0]        funct3_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load encodings.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam funct3_t F3_LB  = 3'd0;
  localparam funct3_t F3_LH  = 3'd1;
  localparam funct3_t F3_LW  = 3'd2;
  localparam funct3_t F3_LD  = 3'd3;
  localparam funct3_t F3_LBU = 3'd4;
  localparam funct3_t F3_LHU = 3'd5;
  localparam funct3_t F3_LWU = 3'd6;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // store encodings.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam funct3_t F3_SB = 3'd0;
  localparam funct3_t F3_SH = 3'd1;
  localparam funct3_t F3_SW = 3'd2;
  localparam funct3_t F3_SD = 3'd3;

endpackage
